// File: common/uart_pkg.sv
// Shared definitions for the APB serial port
// Register offsets, status bit positions, receiver states, APB address width

package uart_pkg;

	// APB address bus width
	localparam int APB_ADDR_WIDTH = 4;

	// Register offsets on the APB bus
	typedef enum logic [3:0]
	{
		REG_STATUS = 4'h0,
		REG_DATA = 4'h4
	} reg_addr_e;

	// Status register bit positions
	// Received character waiting in rx FIFO
	localparam int STATUS_RX_AVAIL = 0;
	// No room left in tx FIFO
	localparam int STATUS_TX_FULL = 1;
	// tx FIFO empty and transmitter ready
	localparam int STATUS_TX_IDLE = 2;
	// Sticky, stop bit sampled low
	localparam int STATUS_FRAME_ERR = 3;
	// Sticky, good character dropped on full rx FIFO
	localparam int STATUS_OVERRUN = 4;

	// Receiver FSM states
	typedef enum logic [1:0]
	{
		// Waiting for falling edge
		RX_IDLE,
		// Confirming start bit at half a bit
		RX_START,
		// Sampling 8 data bits at mid-bit
		RX_DATA,
		// Sampling stop bit
		RX_STOP
	} rx_state_e;

endpackage

// File: logic/apb_uart_regs.sv
// APB slave register block for the serial port
// Register decode, one wait state reads, pslverr rules
// FIFO push/pop control and sticky frame/overrun flags

module apb_uart_regs
	(input                                    clk,
	input                                     reset,
	input [uart_pkg::APB_ADDR_WIDTH - 1:0]    paddr,
	input                                     psel,
	input                                     penable,
	input                                     pwrite,
	input [7:0]                               pwdata,
	output logic [7:0]                        prdata,
	output logic                              pready,
	output logic                              pslverr,
	output logic                              tx_push,
	output logic [7:0]                        tx_push_data,
	input                                     tx_full,
	input                                     tx_idle,
	output logic                              rx_push,
	output logic [7:0]                        rx_push_data,
	input                                     rx_full,
	output logic                              rx_pop,
	input [7:0]                               rx_pop_data,
	input                                     rx_empty,
	input                                     rx_valid,
	input [7:0]                               rx_char,
	input                                     rx_frame_error);

	logic access;
	logic wr_access;
	logic rd_first;
	logic rd_wait;
	logic rd_status_q;
	logic rd_err_q;
	logic wr_err;
	logic rd_err;
	logic is_status;
	logic is_data;
	logic frame_err_flag;
	logic overrun_flag;
	logic status_clear;
	logic [7:0] status_word;
	logic [7:0] rd_data_next;

	// Address decode
	always_comb
	begin
		is_status = 1'b0;
		is_data = 1'b0;
		case (uart_pkg::reg_addr_e'(paddr))
			uart_pkg::REG_STATUS: is_status = 1'b1;
			uart_pkg::REG_DATA: is_data = 1'b1;
			default: ;
		endcase
	end

	// Access phase tracking
	assign access = psel && penable;
	assign wr_access = access && pwrite;
	// First access cycle of a read, data captured here
	assign rd_first = access && !pwrite && !rd_wait;

	// Writes finish at once, reads after one wait state
	assign pready = wr_access || (access && rd_wait);

	// Write errors: unmapped, status write, data write on full FIFO
	assign wr_err = !(is_status || is_data) || is_status || (is_data && tx_full);
	// Read errors: unmapped, data read on empty FIFO
	assign rd_err = !(is_status || is_data) || (is_data && rx_empty);
	assign pslverr = wr_access ? wr_err : (access && rd_wait && rd_err_q);

	// Character writes go straight to the tx FIFO
	assign tx_push = wr_access && is_data && !tx_full;
	assign tx_push_data = pwdata;

	// Pop in the same cycle the character is captured
	assign rx_pop = rd_first && is_data && !rx_empty;

	// Good characters only, dropped when FIFO full
	assign rx_push = rx_valid && !rx_frame_error && !rx_full;
	assign rx_push_data = rx_char;

	// Flags clear while the status read completes
	assign status_clear = access && rd_wait && rd_status_q;

	always_comb
	begin
		status_word = '0;
		status_word[uart_pkg::STATUS_RX_AVAIL] = !rx_empty;
		status_word[uart_pkg::STATUS_TX_FULL] = tx_full;
		status_word[uart_pkg::STATUS_TX_IDLE] = tx_idle;
		status_word[uart_pkg::STATUS_FRAME_ERR] = frame_err_flag;
		status_word[uart_pkg::STATUS_OVERRUN] = overrun_flag;
	end

	// Read mux, zero on errors
	always_comb
	begin
		rd_data_next = '0;
		if (is_status)
			rd_data_next = status_word;
		else if (is_data && !rx_empty)
			rd_data_next = rx_pop_data;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			rd_wait <= 1'b0;
			rd_status_q <= 1'b0;
			rd_err_q <= 1'b0;
			frame_err_flag <= 1'b0;
			overrun_flag <= 1'b0;
		end
		else
		begin
			rd_wait <= rd_first;
			if (rd_first)
			begin
				rd_status_q <= is_status;
				rd_err_q <= rd_err;
			end

			// New events win over a clear in the same cycle
			if (rx_valid && rx_frame_error)
				frame_err_flag <= 1'b1;
			else if (status_clear)
				frame_err_flag <= 1'b0;

			if (rx_valid && !rx_frame_error && rx_full)
				overrun_flag <= 1'b1;
			else if (status_clear)
				overrun_flag <= 1'b0;
		end
	end

	// Registered read data
	always_ff @(posedge clk)
	begin
		if (rd_first)
			prdata <= rd_data_next;
	end
endmodule

// File: logic/sync_fifo.sv
// Synchronous FIFO for 8-bit characters
// Circular buffer with read/write pointers and occupancy count

module sync_fifo
	#(parameter int FIFO_DEPTH = 8)
	(input                clk,
	input                 reset,
	input                 push,
	input [7:0]           push_data,
	input                 pop,
	output logic [7:0]    pop_data,
	output logic          full,
	output logic          empty);

	// Depth must be at least 2
	localparam int PTR_WIDTH = $clog2(FIFO_DEPTH);
	localparam int COUNT_WIDTH = $clog2(FIFO_DEPTH + 1);

	logic [7:0] mem[FIFO_DEPTH];
	logic [PTR_WIDTH - 1:0] wr_ptr;
	logic [PTR_WIDTH - 1:0] rd_ptr;
	logic [COUNT_WIDTH - 1:0] count;
	logic do_push;
	logic do_pop;

	// Push ignored when full, pop ignored when empty
	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	assign full = count == COUNT_WIDTH'(FIFO_DEPTH);
	assign empty = count == 0;

	// Head entry visible without a pop
	assign pop_data = mem[rd_ptr];

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			// Pointers wrap at depth, works for any depth
			if (do_push)
				wr_ptr <= wr_ptr == PTR_WIDTH'(FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;

			if (do_pop)
				rd_ptr <= rd_ptr == PTR_WIDTH'(FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;

			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	// Storage
	always_ff @(posedge clk)
	begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end
endmodule

// File: logic/uart_top.sv
// Serial port top level
// APB register block, tx/rx FIFOs, transmitter and receiver

module uart_top
	#(parameter int CLOCKS_PER_BIT = 16,
	parameter int FIFO_DEPTH = 8)
	(input                                    clk,
	input                                     reset,
	input [uart_pkg::APB_ADDR_WIDTH - 1:0]    paddr,
	input                                     psel,
	input                                     penable,
	input                                     pwrite,
	input [7:0]                               pwdata,
	output logic [7:0]                        prdata,
	output logic                              pready,
	output logic                              pslverr,
	output logic                              uart_tx,
	input                                     uart_rx);

	logic tx_push;
	logic [7:0] tx_push_data;
	logic tx_pop;
	logic [7:0] tx_char;
	logic tx_full;
	logic tx_empty;
	logic tx_enable;
	logic tx_ready;
	logic tx_idle;
	logic rx_push;
	logic [7:0] rx_push_data;
	logic rx_pop;
	logic [7:0] rx_pop_data;
	logic rx_full;
	logic rx_empty;
	logic rx_valid;
	logic [7:0] rx_char;
	logic rx_frame_error;

	// Transmitter takes the FIFO head when ready
	assign tx_enable = !tx_empty;
	assign tx_pop = tx_enable && tx_ready;
	assign tx_idle = tx_empty && tx_ready;

	apb_uart_regs uart_regs(.*);

	sync_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) tx_fifo(
		.clk(clk),
		.reset(reset),
		.push(tx_push),
		.push_data(tx_push_data),
		.pop(tx_pop),
		.pop_data(tx_char),
		.full(tx_full),
		.empty(tx_empty));

	sync_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) rx_fifo(
		.clk(clk),
		.reset(reset),
		.push(rx_push),
		.push_data(rx_push_data),
		.pop(rx_pop),
		.pop_data(rx_pop_data),
		.full(rx_full),
		.empty(rx_empty));

	uart_transmit #(.CLOCKS_PER_BIT(CLOCKS_PER_BIT)) transmitter(.*);

	uart_receive #(.CLOCKS_PER_BIT(CLOCKS_PER_BIT)) receiver(.*);
endmodule

// File: run.sh
#!/bin/bash
# Build and run the serial port testbench with Verilator
# Exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" &&
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f sim.f --top-module uart_tb -o uart_sim &&
	./obj_dir/uart_sim || exit 1

// File: sim.f
common/uart_pkg.sv
logic/sync_fifo.sv
uart/uart_transmit.sv
uart/uart_receive.sv
logic/apb_uart_regs.sv
logic/uart_top.sv
tests/tb_clock.sv
tests/uart_chk.sv
tests/uart_tb.sv

// File: tests/tb_clock.sv
// Testbench clock and reset source
// 40 ns clock, reset held high for 8 cycles

module tb_clock
	(output logic clk,
	output logic reset);

	timeunit 1ns;
	timeprecision 100ps;

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Release just after a rising edge
	initial
	begin
		reset = 1'b1;
		repeat (8) @(posedge clk);
		#2;
		reset = 1'b0;
	end
endmodule

// File: tests/uart_chk.sv
// Concurrent checks on the APB handshake, the tx line and the receiver FSM
// Bound to uart_top

module uart_chk
	(input logic                 clk,
	input logic                  reset,
	input logic                  psel,
	input logic                  penable,
	input logic                  pwrite,
	input logic [7:0]            prdata,
	input logic                  pready,
	input logic                  pslverr,
	input logic                  uart_tx,
	input logic                  tx_ready,
	input uart_pkg::rx_state_e   rx_state);

	timeunit 1ns;
	timeprecision 100ps;

	// Error response only in the completing cycle, failed reads return zero
	pslverr_with_pready: assert property (@(posedge clk) disable iff (reset)
		pslverr |-> pready && (pwrite || prdata == 8'h00))
	else $error("pslverr raised without pready or with nonzero read data");

	// Completion only in the access phase, reads after one wait state
	pready_in_access: assert property (@(posedge clk) disable iff (reset)
		pready |-> psel && penable && (pwrite || $past(psel && penable && !pready)))
	else $error("pready outside the access phase or read done without wait state");

	// Idle line high, last bit before ready is the stop bit
	tx_idle_high: assert property (@(posedge clk) disable iff (reset)
		tx_ready |-> uart_tx && $past(uart_tx))
	else $error("uart_tx low while or just before the transmitter is ready");

	// Data state only follows a confirmed start bit, never reset
	rx_data_entry: assert property (@(posedge clk) disable iff (reset)
		rx_state == uart_pkg::RX_DATA |->
		$past(rx_state) inside {uart_pkg::RX_START, uart_pkg::RX_DATA})
	else $error("Receiver in data state without a confirmed start bit");
endmodule

bind uart_top uart_chk chk(
	.clk(clk),
	.reset(reset),
	.psel(psel),
	.penable(penable),
	.pwrite(pwrite),
	.prdata(prdata),
	.pready(pready),
	.pslverr(pslverr),
	.uart_tx(uart_tx),
	.tx_ready(tx_ready),
	.rx_state(receiver.state));

// File: tests/uart_tb.sv
// Testbench for the APB serial port
// APB tasks, serial line driver, tx frame checker, reference queues
// Random characters from a fixed seed

module uart_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLOCKS_PER_BIT = 16;
	localparam int FIFO_DEPTH = 8;
	localparam int APB_TIMEOUT = 16;
	localparam int FRAME_TIMEOUT = 40 * CLOCKS_PER_BIT;
	localparam int POLL_LIMIT = 100;
	localparam int IDLE_STATUS = 1 << uart_pkg::STATUS_TX_IDLE;
	localparam logic [3:0] BAD_ADDR = 4'h8;

	logic clk;
	logic reset;
	logic [uart_pkg::APB_ADDR_WIDTH - 1:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [7:0] pwdata;
	logic [7:0] prdata;
	logic pready;
	logic pslverr;
	logic uart_tx;
	logic uart_rx;
	logic loopback;
	logic line_drv;
	int seed;
	string test_name;
	// Characters expected on the line and from REG_DATA
	logic [7:0] tx_expect[$];
	logic [7:0] rx_expect[$];

	tb_clock clock_gen(.clk(clk), .reset(reset));

	// Loopback or line driver into the receiver
	assign uart_rx = loopback ? uart_tx : line_drv;

	uart_top dut(.clk(clk), .reset(reset), .paddr(paddr), .psel(psel), .penable(penable),
		.pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .uart_tx(uart_tx), .uart_rx(uart_rx));

	task automatic report_failure();
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic check_value(string what, int expected, int actual);
		assert (expected == actual)
		else
		begin
			$display("Mismatch in %s, %s: expected 0x%0h, actual 0x%0h", test_name, what,
				expected, actual);
			report_failure();
		end
	endtask

	// Drive point, just after the rising edge
	task automatic step_cycle();
		@(posedge clk);
		#2;
	endtask

	// Setup, access, then wait for pready sampled at the falling edge
	task automatic apb_access(input logic [3:0] addr, input logic write, input logic [7:0] wdata,
		output logic [7:0] rdata, output logic err);
		int waited;
		waited = 0;
		step_cycle();
		paddr = addr;
		pwrite = write;
		pwdata = wdata;
		psel = 1'b1;
		penable = 1'b0;
		step_cycle();
		penable = 1'b1;
		@(negedge clk);
		while (!pready)
		begin
			@(negedge clk);
			waited++;
			if (waited > APB_TIMEOUT)
			begin
				$display("APB transfer in %s never got pready", test_name);
				report_failure();
			end
		end
		rdata = prdata;
		err = pslverr;
		step_cycle();
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_write(input logic [3:0] addr, input logic [7:0] data, output logic err);
		logic [7:0] unused;
		apb_access(addr, 1'b1, data, unused, err);
	endtask

	task automatic apb_read(input logic [3:0] addr, output logic [7:0] data, output logic err);
		apb_access(addr, 1'b0, 8'h00, data, err);
	endtask

	task automatic check_status(int expected);
		logic [7:0] status;
		logic err;
		apb_read(uart_pkg::REG_STATUS, status, err);
		check_value("status error", 0, int'(err));
		check_value("status", expected, int'(status));
	endtask

	// Poll until a received character is waiting
	task automatic wait_rx_avail();
		logic [7:0] status;
		logic err;
		int polls;
		polls = 0;
		apb_read(uart_pkg::REG_STATUS, status, err);
		while (!status[uart_pkg::STATUS_RX_AVAIL])
		begin
			polls++;
			if (polls > POLL_LIMIT)
			begin
				$display("No received character showed up in %s", test_name);
				report_failure();
			end
			apb_read(uart_pkg::REG_STATUS, status, err);
		end
	endtask

	task automatic read_back(int count);
		logic [7:0] data;
		logic err;
		for (int i = 0; i < count; i++)
		begin
			wait_rx_avail();
			apb_read(uart_pkg::REG_DATA, data, err);
			check_value("data read error", 0, int'(err));
			if (rx_expect.size() == 0)
			begin
				$display("Character read in %s with none expected", test_name);
				report_failure();
			end
			check_value("rx character", int'(rx_expect.pop_front()), int'(data));
		end
	endtask

	// Whole frame checked every cycle, data decoded at mid-bit
	task automatic check_frame();
		int waited;
		logic [7:0] expected;
		logic [7:0] decoded;
		logic [9:0] frame;
		waited = 0;
		while (uart_tx !== 1'b0)
		begin
			@(negedge clk);
			waited++;
			if (waited > FRAME_TIMEOUT)
			begin
				$display("No start bit on uart_tx in %s", test_name);
				report_failure();
			end
		end
		if (tx_expect.size() == 0)
		begin
			$display("Frame on uart_tx in %s with no character expected", test_name);
			report_failure();
		end
		expected = tx_expect.pop_front();
		frame = {1'b1, expected, 1'b0};
		decoded = '0;
		for (int b = 0; b < 10; b++)
			for (int c = 0; c < CLOCKS_PER_BIT; c++)
			begin
				check_value("uart_tx bit", int'(frame[b]), int'(uart_tx));
				if (c == CLOCKS_PER_BIT / 2 && b >= 1 && b <= 8)
					decoded[b - 1] = uart_tx;
				@(negedge clk);
			end
		check_value("decoded character", int'(expected), int'(decoded));
	endtask

	// One 8N1 frame on the line, then one idle bit
	task automatic send_frame(input logic [7:0] data, input logic stop);
		logic [9:0] frame;
		frame = {stop, data, 1'b0};
		step_cycle();
		for (int b = 0; b < 10; b++)
		begin
			line_drv = frame[b];
			repeat (CLOCKS_PER_BIT) step_cycle();
		end
		line_drv = 1'b1;
		repeat (CLOCKS_PER_BIT) step_cycle();
	endtask

	task automatic test_loopback();
		int count;
		logic [7:0] data;
		logic err;
		test_name = "loopback";
		loopback = 1'b1;
		repeat (4)
		begin
			count = 1 + ({$random(seed)} % FIFO_DEPTH);
			// Writes overlap the first frames on the line
			fork
				for (int i = 0; i < count; i++)
				begin
					data = 8'($random(seed));
					apb_write(uart_pkg::REG_DATA, data, err);
					check_value("write error", 0, int'(err));
					tx_expect.push_back(data);
					rx_expect.push_back(data);
				end
				repeat (count) check_frame();
			join
			read_back(count);
		end
	endtask

	task automatic test_tx_backpressure();
		logic [7:0] data;
		logic err;
		test_name = "tx back-pressure";
		loopback = 1'b0;
		// One character leaves at once, the FIFO holds the rest
		fork
			begin
				for (int i = 0; i < FIFO_DEPTH + 2; i++)
				begin
					data = 8'($random(seed));
					apb_write(uart_pkg::REG_DATA, data, err);
					check_value("write error", int'(i == FIFO_DEPTH + 1), int'(err));
					if (!err)
						tx_expect.push_back(data);
				end
				// FIFO still full while the first frame is on the line
				check_status(1 << uart_pkg::STATUS_TX_FULL);
			end
			repeat (FIFO_DEPTH + 1) check_frame();
		join
	endtask

	task automatic test_overrun();
		logic [7:0] data;
		logic err;
		test_name = "overrun";
		for (int i = 0; i < FIFO_DEPTH + 1; i++)
		begin
			data = 8'($random(seed));
			send_frame(data, 1'b1);
			if (i < FIFO_DEPTH)
				rx_expect.push_back(data);
		end
		check_status(IDLE_STATUS | (1 << uart_pkg::STATUS_RX_AVAIL) |
			(1 << uart_pkg::STATUS_OVERRUN));
		read_back(FIFO_DEPTH);
		apb_read(uart_pkg::REG_DATA, data, err);
		check_value("empty read error", 1, int'(err));
		check_value("empty read data", 0, int'(data));
		check_status(IDLE_STATUS);
	endtask

	task automatic test_bus_errors();
		logic [7:0] data;
		logic err;
		test_name = "bus errors";
		check_status(IDLE_STATUS);
		apb_write(BAD_ADDR, 8'($random(seed)), err);
		check_value("unmapped write error", 1, int'(err));
		apb_read(BAD_ADDR, data, err);
		check_value("unmapped read error", 1, int'(err));
		check_value("unmapped read data", 0, int'(data));
		apb_write(uart_pkg::REG_STATUS, 8'hff, err);
		check_value("status write error", 1, int'(err));
		check_status(IDLE_STATUS);
	endtask

	initial
	begin
		int waited;
		seed = 32'hbd13_b873;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		loopback = 1'b1;
		line_drv = 1'b1;
		waited = 0;
		while (reset)
		begin
			@(negedge clk);
			waited++;
			if (waited > 20)
			begin
				$display("Reset was never released");
				report_failure();
			end
		end

		// Only tx idle after reset, line stays high
		test_name = "reset";
		check_status(IDLE_STATUS);
		repeat (2 * CLOCKS_PER_BIT)
		begin
			@(negedge clk);
			check_value("idle uart_tx", 1, int'(uart_tx));
		end

		test_loopback();
		test_tx_backpressure();

		// Low stop bit, character dropped, flag clears on read
		test_name = "frame error";
		send_frame(8'($random(seed)), 1'b0);
		check_status(IDLE_STATUS | (1 << uart_pkg::STATUS_FRAME_ERR));
		check_status(IDLE_STATUS);

		test_overrun();
		test_bus_errors();

		$display("All tests passed!");
		$finish;
	end
endmodule

// File: uart/uart_receive.sv
// Serial receiver, 8N1 frame
// Two-flop line synchronizer, mid-bit sampling FSM, stop bit check

module uart_receive
	#(parameter int CLOCKS_PER_BIT = 16)
	(input                clk,
	input                 reset,
	input                 uart_rx,
	output logic          rx_valid,
	output logic [7:0]    rx_char,
	output logic          rx_frame_error);

	// At least 2 clocks per bit for the half-bit wait
	localparam int COUNT_WIDTH = $clog2(CLOCKS_PER_BIT + 1);
	localparam logic [COUNT_WIDTH - 1:0] HALF_BIT = COUNT_WIDTH'(CLOCKS_PER_BIT / 2 - 1);
	localparam logic [COUNT_WIDTH - 1:0] FULL_BIT = COUNT_WIDTH'(CLOCKS_PER_BIT - 1);

	uart_pkg::rx_state_e state;
	logic rx_meta;
	logic rx_sync;
	logic [COUNT_WIDTH - 1:0] bit_clocks;
	logic [2:0] bit_index;
	logic sample;

	// Mid-bit point reached
	assign sample = bit_clocks == 0;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			state <= uart_pkg::RX_IDLE;
			bit_clocks <= '0;
			bit_index <= '0;
			rx_valid <= 1'b0;
			rx_frame_error <= 1'b0;
		end
		else
		begin
			// Line synchronizer, idles high
			rx_meta <= uart_rx;
			rx_sync <= rx_meta;

			// Valid and error are single-cycle pulses
			rx_valid <= 1'b0;
			rx_frame_error <= 1'b0;

			if (!sample)
				bit_clocks <= bit_clocks - 1'b1;

			case (state)
				uart_pkg::RX_IDLE:
				begin
					// Falling edge, wait half a bit
					if (!rx_sync)
					begin
						state <= uart_pkg::RX_START;
						bit_clocks <= HALF_BIT;
					end
				end

				uart_pkg::RX_START:
				begin
					// Line back high before mid-bit is a glitch
					if (rx_sync)
						state <= uart_pkg::RX_IDLE;
					else if (sample)
					begin
						state <= uart_pkg::RX_DATA;
						bit_clocks <= FULL_BIT;
						bit_index <= '0;
					end
				end

				uart_pkg::RX_DATA:
				begin
					if (sample)
					begin
						bit_clocks <= FULL_BIT;
						bit_index <= bit_index + 1'b1;
						if (bit_index == 3'd7)
							state <= uart_pkg::RX_STOP;
					end
				end

				uart_pkg::RX_STOP:
				begin
					// Stop bit must be high
					if (sample)
					begin
						rx_valid <= 1'b1;
						rx_frame_error <= !rx_sync;
						state <= uart_pkg::RX_IDLE;
					end
				end

				default:
					state <= uart_pkg::RX_IDLE;
			endcase
		end
	end

	// Data bits arrive LSB first
	always_ff @(posedge clk)
	begin
		if (state == uart_pkg::RX_DATA && sample)
			rx_char <= {rx_sync, rx_char[7:1]};
	end
endmodule

// File: uart/uart_transmit.sv
// Serial transmitter, 8N1 frame
// Shift register timed by a bit-period down-counter

module uart_transmit
	#(parameter int CLOCKS_PER_BIT = 16)
	(input                clk,
	input                 reset,
	input                 tx_enable,
	output logic          tx_ready,
	input [7:0]           tx_char,
	output logic          uart_tx);

	localparam int COUNT_WIDTH = $clog2(CLOCKS_PER_BIT + 1);
	localparam logic START_BIT = 1'b0;
	localparam logic STOP_BIT = 1'b1;

	// Start, data LSB first, stop
	logic [9:0] tx_shift;
	// Bits left in the frame
	logic [3:0] shift_count;
	// Cycles left in the current bit
	logic [COUNT_WIDTH - 1:0] next_edge_clocks;
	logic transmit_active;
	logic load;

	assign transmit_active = shift_count != 0;
	assign load = tx_enable && !transmit_active;
	// Line idles high
	assign uart_tx = transmit_active ? tx_shift[0] : 1'b1;
	assign tx_ready = !transmit_active;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			shift_count <= '0;
			next_edge_clocks <= '0;
		end
		else if (transmit_active)
		begin
			// End of bit period, move to next bit
			if (next_edge_clocks == 0)
			begin
				shift_count <= shift_count - 4'd1;
				next_edge_clocks <= COUNT_WIDTH'(CLOCKS_PER_BIT - 1);
			end
			else
				next_edge_clocks <= next_edge_clocks - 1'b1;
		end
		else if (load)
		begin
			shift_count <= 4'd10;
			next_edge_clocks <= COUNT_WIDTH'(CLOCKS_PER_BIT - 1);
		end
	end

	// Frame payload
	always_ff @(posedge clk)
	begin
		if (load)
			tx_shift <= {STOP_BIT, tx_char, START_BIT};
		else if (transmit_active && next_edge_clocks == 0)
			tx_shift <= {1'b1, tx_shift[9:1]};
	end
endmodule
